// ==== vlog.f ====
src/cache_pkg.sv
src/cache_way.sv
src/cache_ctrl.sv
src/cache_top.sv
testbench/cache_checker.sv
testbench/cache_tb.sv

// ==== Makefile ====
obj_dir/Vcache_tb: vlog.f $(wildcard src/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing --assert -j 0 --top-module cache_tb -f vlog.f

.PHONY: run clean

run: obj_dir/Vcache_tb
	./obj_dir/Vcache_tb | tee sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/cache_tb.sv ====
`timescale 1ns/1ns

module cache_tb import cache_pkg::*; ();

    localparam int NUM_RANDOM = 260;
    localparam int MAX_CYCLES = 400 * 14 + 16 * 6; // accesses plus flush lines

    logic        clk;
    logic        rst;
    logic        enable;
    cpu_req_t    cpu_req;
    logic        done;
    logic [15:0] rdata;
    logic        flush;
    logic        flush_done;
    logic        mem_req;
    mem_req_t    mem;
    logic        mem_rdy;
    logic [63:0] mem_rdata;

    integer      seed = 32'h4f08_bd46;
    int          cycles = 0;
    logic [15:0] model [65536];    // expected word per address
    logic [63:0] mem_arr [16384];  // backing memory with one entry per line
    logic        touched [16384];
    logic [63:0] unc_line;         // expected contents of the uncached line
    line_addr_t  cur_line;
    mem_req_t    mreq;
    int          mdelay;
    logic [31:0] r;
    logic [15:0] addr;

    cache_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .cpu_req    (cpu_req),
        .done       (done),
        .rdata      (rdata),
        .flush      (flush),
        .flush_done (flush_done),
        .mem_req    (mem_req),
        .mem        (mem),
        .mem_rdy    (mem_rdy),
        .mem_rdata  (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [15:0] pattern(input logic [15:0] a);
        return (a * 16'h9e37) ^ {a[7:0], a[15:8]} ^ 16'h3c5a;
    endfunction

    function automatic logic [63:0] model_line(input line_addr_t la);
        return {model[{la, 2'd3}], model[{la, 2'd2}], model[{la, 2'd1}], model[{la, 2'd0}]};
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic do_access(input logic [15:0] a, input logic wr, input logic [15:0] wd);
        cpu_req_t    req;
        logic [15:0] exp;
        req.addr  = a;
        req.write = wr;
        req.wdata = wd;
        if (a == UNCACHED_ADDR) begin
            exp = unc_line[15:0];
            if (wr) begin
                unc_line = {48'b0, wd};
            end
        end else begin
            exp              = model[a];
            cur_line         = a[15:2];
            touched[a[15:2]] = 1'b1;
            if (wr) begin
                model[a] = wd;
            end
        end
        @(posedge clk);
        enable  <= 1'b1;
        cpu_req <= req;
        do @(negedge clk); while (!done);
        if (!wr) begin
            check_val("rdata", 64'(rdata), 64'(exp));
        end
        @(posedge clk);
        enable <= 1'b0;
    endtask

    task automatic run_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        do @(negedge clk); while (!flush_done);
    endtask

    // reactive memory answering after 1 to 4 cycles
    always begin
        @(negedge clk);
        if (rst && mem_req) begin
            mreq = mem;
            if (mreq.write && mreq.addr == 14'h3fff) begin
                check_val("mem.wdata", mreq.wdata, unc_line);
            end else if (mreq.write) begin
                check_val("mem.wdata", mreq.wdata, model_line(mreq.addr));
            end else if (mreq.addr != 14'h3fff) begin
                check_val("mem.addr", 64'(mreq.addr), 64'(cur_line));
            end
            mdelay = 1 + int'($unsigned($random(seed)) % 4);
            repeat (mdelay) @(posedge clk);
            if (mreq.write) begin
                mem_arr[mreq.addr] = mreq.wdata;
            end else begin
                mem_rdata <= mem_arr[mreq.addr];
            end
            mem_rdy <= 1'b1;
            @(posedge clk);
            mem_rdy <= 1'b0;
            @(negedge clk);
            check_val("mem_req", 64'(mem_req), 64'd0); // drops on the edge after mem_rdy
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the test did not finish", cycles);
            $display("Verification failed");
            $fatal(1, "cycle limit reached");
        end
    end

    initial begin
        rst       = 1'b0;
        enable    = 1'b0;
        cpu_req   = '0;
        flush     = 1'b0;
        mem_rdy   = 1'b0;
        mem_rdata = '0;
        for (int i = 0; i < 65536; i++) begin
            model[i]                          = pattern(16'(i));
            mem_arr[i >> 2][(i % 4) * 16 +: 16] = pattern(16'(i));
        end
        for (int i = 0; i < 16384; i++) begin
            touched[i] = 1'b0;
        end
        unc_line = mem_arr[16383];
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_val("done", 64'(done), 64'd0);
        check_val("mem_req", 64'(mem_req), 64'd0);
        check_val("flush_done", 64'(flush_done), 64'd0);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            r = $random(seed);
            if (($unsigned($random(seed)) % 20) == 0) begin
                addr = UNCACHED_ADDR;
            end else begin
                addr = {9'b0, r[1:0], r[4:2], r[6:5]}; // tags 0 to 3 force conflicts
            end
            do_access(addr, r[7], r[31:16]);
        end

        run_flush();
        for (int i = 0; i < 16384; i++) begin
            if (touched[i]) begin
                check_val("mem line", mem_arr[i], model_line(14'(i)));
            end
        end
        check_val("mem line 3fff", mem_arr[16383], unc_line);

        // read back every word of the touched lines
        for (int i = 0; i < 16384; i++) begin
            if (touched[i]) begin
                for (int w = 0; w < 4; w++) begin
                    do_access({14'(i), 2'(w)}, 1'b0, 16'h0000);
                end
            end
        end

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== testbench/cache_checker.sv ====
`timescale 1ns/1ns

module cache_checker import cache_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     done,
    input logic     mem_req,
    input logic     mem_rdy,
    input mem_req_t mem
);

    rdy_with_req: assert property (@(posedge clk) disable iff (!rst) mem_rdy |-> mem_req)
        else $error("mem_rdy high while mem_req is low");

    done_pulse: assert property (@(posedge clk) disable iff (!rst) done |=> !done)
        else $error("done high for two cycles");

    done_no_req: assert property (@(posedge clk) disable iff (!rst) !(done && mem_req))
        else $error("done and mem_req high together");

    mem_stable: assert property (@(posedge clk) disable iff (!rst)
        (mem_req && !mem_rdy) |=> $stable(mem))
        else $error("memory request changed before mem_rdy");

endmodule

bind cache_top cache_checker checker_i (
    .clk     (clk),
    .rst     (rst),
    .done    (done),
    .mem_req (mem_req),
    .mem_rdy (mem_rdy),
    .mem     (mem)
);

// ==== src/cache_top.sv ====
`timescale 1ns/1ns

module cache_top import cache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        enable,
    input  cpu_req_t    cpu_req,
    output logic        done,
    output logic [15:0] rdata,
    input  logic        flush,
    output logic        flush_done,
    output logic        mem_req,
    output mem_req_t    mem,
    input  logic        mem_rdy,
    input  logic [63:0] mem_rdata
);

    logic [2:0] way_index;
    logic write_word0;
    logic write_word1;
    logic fill0;
    logic fill1;
    logic clean0;
    logic clean1;
    logic hit0;
    logic hit1;
    line_t entry0;
    line_t entry1;

    cache_way way0_i (
        .clk        (clk),
        .rst        (rst),
        .index      (way_index),
        .cmp_tag    (cpu_req.addr.tag),
        .write_word (write_word0),
        .fill       (fill0),
        .clean      (clean0),
        .req        (cpu_req),
        .fill_data  (mem_rdata),
        .entry      (entry0),
        .hit        (hit0)
    );

    cache_way way1_i (
        .clk        (clk),
        .rst        (rst),
        .index      (way_index),
        .cmp_tag    (cpu_req.addr.tag),
        .write_word (write_word1),
        .fill       (fill1),
        .clean      (clean1),
        .req        (cpu_req),
        .fill_data  (mem_rdata),
        .entry      (entry1),
        .hit        (hit1)
    );

    cache_ctrl ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .cpu_req     (cpu_req),
        .flush       (flush),
        .hit0        (hit0),
        .hit1        (hit1),
        .entry0      (entry0),
        .entry1      (entry1),
        .mem_rdy     (mem_rdy),
        .mem_rdata   (mem_rdata),
        .done        (done),
        .rdata       (rdata),
        .flush_done  (flush_done),
        .way_index   (way_index),
        .write_word0 (write_word0),
        .write_word1 (write_word1),
        .fill0       (fill0),
        .fill1       (fill1),
        .clean0      (clean0),
        .clean1      (clean1),
        .mem_req     (mem_req),
        .mem         (mem)
    );

endmodule

// ==== src/cache_ctrl.sv ====
`timescale 1ns/1ns

module cache_ctrl import cache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        enable,
    input  cpu_req_t    cpu_req,
    input  logic        flush,
    input  logic        hit0,
    input  logic        hit1,
    input  line_t       entry0,
    input  line_t       entry1,
    input  logic        mem_rdy,
    input  logic [63:0] mem_rdata,
    output logic        done,
    output logic [15:0] rdata,
    output logic        flush_done,
    output logic [2:0]  way_index,
    output logic        write_word0,
    output logic        write_word1,
    output logic        fill0,
    output logic        fill1,
    output logic        clean0,
    output logic        clean1,
    output logic        mem_req,
    output mem_req_t    mem
);

    localparam int FLUSH_LAST = NUM_SETS * NUM_WAYS - 1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_GAP,    // done cycle with enable ignored
        ST_WB,
        ST_FILL,
        ST_UNC,
        ST_FLUSH
    } state_t;

    state_t state;
    logic [NUM_SETS-1:0] victim;  // round robin bit per set
    logic [3:0] flush_cnt;        // {set, way}

    line_t hit_line;
    line_t vic_entry;
    line_t flush_line;
    logic [15:0] hit_word;
    logic vic_way;
    logic flush_way;
    logic uncached;
    logic accept;
    logic hit_done;
    logic miss_start;
    logic unc_start;
    logic wb_start;
    logic rd_start;
    logic fl_wb_start;
    logic flush_step;
    logic mem_ack;
    logic wb_ack;
    logic fl_ack;
    logic fill_now;

    assign flush_way = flush_cnt[0];
    assign way_index = (state == ST_FLUSH) ? flush_cnt[3:1] : cpu_req.addr.index;

    assign hit_line   = hit1 ? entry1 : entry0;
    assign hit_word   = hit_line.data[{cpu_req.addr.offset, 4'b0000} +: 16];
    assign vic_way    = victim[cpu_req.addr.index];
    assign vic_entry  = vic_way ? entry1 : entry0;
    assign flush_line = flush_way ? entry1 : entry0;

    assign uncached   = (cpu_req.addr == UNCACHED_ADDR);
    assign accept     = (state == ST_IDLE) && !flush && enable; // flush wins over enable
    assign unc_start  = accept && uncached;
    assign hit_done   = accept && !uncached && (hit0 || hit1);
    assign miss_start = accept && !uncached && !(hit0 || hit1);
    assign wb_start   = miss_start && vic_entry.dirty;
    assign rd_start   = (miss_start && !vic_entry.dirty) || (state == ST_FILL && !mem_req);

    assign mem_ack     = mem_req && mem_rdy;
    assign wb_ack      = (state == ST_WB) && mem_ack;
    assign fill_now    = (state == ST_FILL) && mem_ack;
    assign fl_ack      = (state == ST_FLUSH) && mem_ack;
    assign fl_wb_start = (state == ST_FLUSH) && !mem_req && flush_line.dirty;
    assign flush_step  = ((state == ST_FLUSH) && !mem_req && !flush_line.dirty) || fl_ack;

    // way strobes
    assign write_word0 = hit_done && cpu_req.write && hit0;
    assign write_word1 = hit_done && cpu_req.write && hit1;
    assign fill0       = fill_now && !vic_way;
    assign fill1       = fill_now && vic_way;
    assign clean0      = (wb_ack && !vic_way) || (fl_ack && !flush_way);
    assign clean1      = (wb_ack && vic_way) || (fl_ack && flush_way);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= ST_IDLE;
            done       <= 1'b0;
            flush_done <= 1'b0;
            mem_req    <= 1'b0;
            victim     <= '0;
            flush_cnt  <= '0;
        end else begin
            done       <= 1'b0; // both are single-cycle pulses
            flush_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (flush) begin
                        flush_cnt <= '0;
                        state     <= ST_FLUSH;
                    end else if (unc_start) begin
                        mem_req <= 1'b1;
                        state   <= ST_UNC;
                    end else if (hit_done) begin
                        done  <= 1'b1;
                        state <= ST_GAP;
                    end else if (miss_start) begin
                        mem_req <= 1'b1;
                        state   <= wb_start ? ST_WB : ST_FILL;
                    end
                end
                ST_GAP: state <= ST_IDLE;
                ST_WB: begin
                    if (mem_rdy) begin
                        mem_req <= 1'b0; // read goes out after a low cycle
                        state   <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (!mem_req) begin
                        mem_req <= 1'b1;
                    end else if (mem_rdy) begin
                        mem_req                       <= 1'b0;
                        victim[cpu_req.addr.index]    <= ~vic_way;
                        state                         <= ST_IDLE; // replays as a hit
                    end
                end
                ST_UNC: begin
                    if (mem_rdy) begin
                        mem_req <= 1'b0;
                        done    <= 1'b1;
                        state   <= ST_GAP;
                    end
                end
                ST_FLUSH: begin
                    if (fl_wb_start) begin
                        mem_req <= 1'b1;
                    end else if (fl_ack) begin
                        mem_req <= 1'b0;
                    end
                    if (flush_step) begin
                        if (flush_cnt == 4'(FLUSH_LAST)) begin
                            flush_done <= 1'b1;
                            state      <= ST_IDLE;
                        end else begin
                            flush_cnt <= flush_cnt + 4'd1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request payload and read data
    always_ff @(posedge clk) begin
        if (wb_start) begin
            mem.write <= 1'b1;
            mem.addr  <= {vic_entry.tag, cpu_req.addr.index};
            mem.wdata <= vic_entry.data;
        end else if (rd_start) begin
            mem.write <= 1'b0;
            mem.addr  <= {cpu_req.addr.tag, cpu_req.addr.index};
            mem.wdata <= '0;
        end else if (unc_start) begin
            mem.write <= cpu_req.write;
            mem.addr  <= '1;
            mem.wdata <= cpu_req.write ? {48'b0, cpu_req.wdata} : 64'b0;
        end else if (fl_wb_start) begin
            mem.write <= 1'b1;
            mem.addr  <= {flush_line.tag, flush_cnt[3:1]};
            mem.wdata <= flush_line.data;
        end

        if (hit_done && !cpu_req.write) begin
            rdata <= hit_word;
        end else if ((state == ST_UNC) && mem_ack && !mem.write) begin
            rdata <= mem_rdata[15:0]; // word 0 of the uncached line
        end
    end

endmodule

// ==== src/cache_way.sv ====
`timescale 1ns/1ns

module cache_way import cache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [2:0]  index,
    input  logic [10:0] cmp_tag,
    input  logic        write_word,
    input  logic        fill,
    input  logic        clean,
    input  cpu_req_t    req,
    input  logic [63:0] fill_data,
    output line_t       entry,
    output logic        hit
);

    line_t lines [NUM_SETS];
    line_t cur;
    logic [5:0] word_lsb;

    assign cur      = lines[index];
    assign word_lsb = {req.addr.offset, 4'b0000}; // offset * 16

    assign entry = cur;
    assign hit   = cur.valid && (cur.tag == cmp_tag);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                lines[i] <= '0;
            end
        end else if (fill) begin
            lines[index].valid <= 1'b1;
            lines[index].dirty <= 1'b0;
            lines[index].tag   <= cmp_tag;
            lines[index].data  <= fill_data;
        end else if (write_word) begin
            lines[index].dirty                 <= 1'b1;
            lines[index].data[word_lsb +: 16]  <= req.wdata;
        end else if (clean) begin
            lines[index].dirty <= 1'b0; // line now matches memory
        end
    end

endmodule

// ==== src/cache_pkg.sv ====
package cache_pkg;

    localparam int NUM_SETS = 8;
    localparam int NUM_WAYS = 2;

    localparam logic [15:0] UNCACHED_ADDR = 16'hffff; // bypasses the cache

    // processor word address
    typedef struct packed {
        logic [10:0] tag;
        logic [2:0]  index;
        logic [1:0]  offset;
    } word_addr_t;

    // memory line address
    typedef struct packed {
        logic [10:0] tag;
        logic [2:0]  index;
    } line_addr_t;

    // one cache entry with word 0 in data[15:0]
    typedef struct packed {
        logic        valid;
        logic        dirty;
        logic [10:0] tag;
        logic [63:0] data;
    } line_t;

    typedef struct packed {
        word_addr_t  addr;
        logic        write;  // 1 = store, 0 = load
        logic [15:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic        write;  // 1 = line write, 0 = line read
        line_addr_t  addr;
        logic [63:0] wdata;
    } mem_req_t;

endpackage
